/* dv/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock #(
    parameter int half_period = 50,
    parameter int reset_cycles = 16
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #half_period clk = ~clk;
        end
    end

    // Start low so the asynchronous resets see a rising edge.
    initial begin
        rst = 1'b0;
        #1;
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #10;
        rst = 1'b0;
    end

endmodule

/* dv/usb_link_tx_properties.sv */
`timescale 1ns/10ps

module usb_link_tx_properties (
    input logic       clk,
    input logic       rst,
    input logic       fs,
    input logic       fd,
    input logic       pop,
    input logic [7:0] usb_txd
);

    // Request stays up until the builder answers.
    property fs_holds_until_fd;
        @(posedge clk) disable iff (rst) (fs && !fd) |=> fs;
    endproperty

    // Done may outlive fs by the one cycle the builder needs to see it fall.
    property fd_needs_fs;
        @(posedge clk) disable iff (rst) fd |-> (fs || $past(fs));
    endproperty

    property pop_with_fs_fall;
        @(posedge clk) disable iff (rst) pop |-> $fell(fs);
    endproperty

    property txd_idle_in_reset;
        @(posedge clk) rst |-> (usb_txd == 8'h00);
    endproperty

    assert property (fs_holds_until_fd) else $error("fs dropped before fd was seen");
    assert property (fd_needs_fs) else $error("fd high without fs");
    assert property (pop_with_fs_fall) else $error("pop without a fall of fs");
    assert property (txd_idle_in_reset) else $error("usb_txd not zero during reset");

endmodule

bind usb_link_tx usb_link_tx_properties usb_link_tx_properties_inst (
    .clk     (clk),
    .rst     (rst),
    .fs      (fs),
    .fd      (fd),
    .pop     (pop),
    .usb_txd (usb_txd)
);

/* dv/usb_link_tx_tb.sv */
`timescale 1ns/10ps

module usb_link_tx_tb
    import usb_pkt_pkg::*, dev_cmd_pkg::*;
;

    localparam int preamble_len = 2;
    localparam int fifo_depth = 4;
    localparam int reset_cycles = 16;
    localparam int num_frames = 14;
    localparam int max_frame_len = preamble_len + 7;
    localparam int watchdog_cycles = reset_cycles + 8 + num_frames * max_frame_len * 4;

    logic       clk;
    logic       rst;
    logic       req_push;
    tx_req_t    req;
    logic       full;
    logic       busy;
    logic [7:0] usb_txd;

    logic [31:0] rng_state = 32'hfdb;
    int          errors = 0;
    int          tests_run = 0;
    int          frames_pushed = 0;
    int          frames_done = 0;

    // Expected bytes of all pending frames back to back.
    logic [7:0] exp_bytes [$];
    int         exp_len [$];
    string      exp_name [$];

    logic  in_frame = 1'b0;
    int    cur_len;
    int    byte_idx;
    int    gap = 2;
    string cur_name;

    tb_clock #(
        .half_period  (50),
        .reset_cycles (reset_cycles)
    ) tb_clock_inst (
        .clk (clk),
        .rst (rst)
    );

    usb_link_tx #(
        .preamble_len (preamble_len),
        .fifo_depth   (fifo_depth)
    ) usb_link_tx_inst (
        .clk      (clk),
        .rst      (rst),
        .req_push (req_push),
        .req      (req),
        .full     (full),
        .busy     (busy),
        .usb_txd  (usb_txd)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // USB CRC-5 with the bits taken least significant first.
    function automatic logic [4:0] crc5_step(input logic [4:0] r, input logic [7:0] b);
        logic [4:0] c;
        c = r;
        for (int i = 0; i < 8; i++) begin
            if (b[i] ^ c[4]) begin
                c = {c[3:0], 1'b0} ^ 5'h05;
            end else begin
                c = {c[3:0], 1'b0};
            end
        end
        return c;
    endfunction

    task automatic expect_frame(input bag_type_t kind, input dev_cmd_t cmd, input string name);
        logic [7:0] body [$];
        logic [7:0] frame [$];
        logic [7:0] pid;
        logic [4:0] crc;
        case (kind)
            BAG_ACK: pid = 8'h2D;
            BAG_NAK: pid = 8'hA5;
            BAG_RLY: pid = 8'hE1;
            default: pid = 8'h1E;
        endcase
        case (kind)
            BAG_DIDX: body.push_back({4'h9, cmd.device_idx});
            BAG_DDIDX: body.push_back({4'h1, cmd.data_idx});
            BAG_LINK: body.push_back(8'hB0);
            BAG_DPARAM: begin
                body.push_back({4'h5, cmd.freq_samp});
                body.push_back({cmd.filt_up, cmd.filt_low});
            end
            default: ;
        endcase
        for (int i = 0; i < preamble_len; i++) begin
            frame.push_back(8'h5A);
        end
        frame.push_back(8'h01);
        frame.push_back(pid);
        if (body.size() > 0) begin
            frame.push_back(8'h00);
            frame.push_back(8'(body.size()));
            crc = crc5_step(5'h1F, 8'(body.size()));
            foreach (body[i]) begin
                frame.push_back(body[i]);
                crc = crc5_step(crc, body[i]);
            end
            frame.push_back({3'b000, ~crc});
        end
        foreach (frame[i]) begin
            exp_bytes.push_back(frame[i]);
        end
        exp_len.push_back(frame.size());
        exp_name.push_back(name);
    endtask

    task automatic wait_drive_point();
        @(posedge clk);
        #10;
    endtask

    task automatic push_req(input bag_type_t kind, input dev_cmd_t cmd, input string name);
        while (full) begin
            wait_drive_point();
        end
        req_push = 1'b1;
        req.kind = kind;
        req.cmd = cmd;
        expect_frame(kind, cmd, name);
        frames_pushed++;
        wait_drive_point();
        req_push = 1'b0;
    endtask

    task automatic wait_done();
        @(negedge clk);
        while (busy || frames_done != frames_pushed) begin
            @(negedge clk);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        $display("Test %s: %s", name, (errors == errs_before) ? "ok" : "failed");
    endtask

    task automatic check_idle(input string name);
        assert (busy == 1'b0) else begin
            $display("Mismatch in %s: busy expected 0, actual %0b", name, busy);
            errors++;
        end
        assert (usb_txd == 8'h00) else begin
            $display("Mismatch in %s: usb_txd expected 0x00, actual 0x%02h", name, usb_txd);
            errors++;
        end
    endtask

    task automatic run_single(input bag_type_t kind, input string name);
        int errs_before;
        errs_before = errors;
        rng_state = xorshift32(rng_state);
        wait_drive_point();
        push_req(kind, dev_cmd_t'(rng_state), name);
        wait_done();
        report_test(name, errs_before);
    endtask

    function automatic void start_frame();
        assert (exp_len.size() > 0) else begin
            $display("Unexpected frame on usb_txd with no request pending");
            errors++;
        end
        if (exp_len.size() > 0) begin
            cur_len = exp_len.pop_front();
            cur_name = exp_name.pop_front();
            byte_idx = 0;
            in_frame = 1'b1;
            assert (gap >= 2) else begin
                $display("Mismatch in %s: idle gap expected at least 2, actual %0d",
                         cur_name, gap);
                errors++;
            end
        end
    endfunction

    function automatic void check_byte();
        logic [7:0] want;
        want = exp_bytes.pop_front();
        assert (usb_txd == want) else begin
            $display("Mismatch in %s: byte %0d expected 0x%02h, actual 0x%02h",
                     cur_name, byte_idx, want, usb_txd);
            errors++;
        end
        assert (busy) else begin
            $display("Mismatch in %s: busy at byte %0d expected 1, actual %0b",
                     cur_name, byte_idx, busy);
            errors++;
        end
        byte_idx++;
        if (byte_idx == cur_len) begin
            in_frame = 1'b0;
            frames_done++;
            gap = 0;
        end
    endfunction

    // Frame monitor samples away from the rising edge.
    always @(negedge clk) begin
        if (rst) begin
            in_frame = 1'b0;
            gap = 2;
        end else if (!in_frame && usb_txd == 8'h00) begin
            gap++;
        end else begin
            if (!in_frame) begin
                start_frame();
            end
            if (in_frame) begin
                check_byte();
            end
        end
    end

    initial begin
        int        errs_before;
        bag_type_t kind;
        req_push = 1'b0;
        req = '0;

        errs_before = errors;
        @(negedge clk);
        while (rst) begin
            check_idle("reset_idle");
            @(negedge clk);
        end
        repeat (8) begin
            check_idle("reset_idle");
            @(negedge clk);
        end
        report_test("reset_idle", errs_before);

        run_single(BAG_ACK, "handshake_ack");
        run_single(BAG_NAK, "handshake_nak");
        run_single(BAG_RLY, "handshake_rly");
        run_single(BAG_DIDX, "cmd_didx");
        run_single(BAG_DDIDX, "cmd_ddidx");
        run_single(BAG_LINK, "cmd_link");
        run_single(BAG_DPARAM, "cmd_dparam_a");
        run_single(BAG_DPARAM, "cmd_dparam_b");

        // Burst longer than the queue, so full has to hold pushes back.
        errs_before = errors;
        wait_drive_point();
        for (int n = 0; n < fifo_depth + 2; n++) begin
            rng_state = xorshift32(rng_state);
            kind = bag_type_t'(4'(rng_state % 32'd7 + 32'd1));
            rng_state = xorshift32(rng_state);
            // The first frame outlasts the queue, so it fills before any pop.
            assert (full == (n >= fifo_depth)) else begin
                $display("Mismatch in burst: full before push %0d expected %0b, actual %0b",
                         n, n >= fifo_depth, full);
                errors++;
            end
            push_req(kind, dev_cmd_t'(rng_state), "burst");
        end
        wait_done();
        report_test("burst", errs_before);

        $display("Tests run: %0d, frames checked: %0d, errors: %0d",
                 tests_run, frames_done, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, %0d of %0d frames seen",
                 watchdog_cycles, frames_done, frames_pushed);
        $display("Finished with errors");
        $finish;
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the pass line appears.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module usb_link_tx_tb \
    -f usb_link_tx.f -o usb_link_tx_sim || exit 1
out=$(./obj_dir/usb_link_tx_sim +verilator+error+limit+100)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Finished with no errors" && exit 0 || exit 1

/* src/crc5.sv */
`timescale 1ns/10ps

module crc5 (
    input  logic       clk,
    input  logic       rst,
    input  logic       init,
    input  logic       enable,
    input  logic [7:0] din,
    output logic [7:0] dout
);

    // x^5 + x^2 + 1
    localparam logic [4:0] poly = 5'b00101;
    localparam logic [4:0] seed = 5'h1F;

    logic [4:0] crc;
    logic [4:0] crc_next;

    // Fold one byte in, least significant bit first.
    always_comb begin
        logic fb;
        crc_next = crc;
        for (int i = 0; i < 8; i++) begin
            fb = din[i] ^ crc_next[4];
            crc_next = {crc_next[3:0], 1'b0} ^ (fb ? poly : 5'b00000);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            crc <= seed;
        end else if (init) begin
            crc <= seed;
        end else if (enable) begin
            crc <= crc_next;
        end
    end

    assign dout = {3'b000, ~crc};

endmodule

/* src/dev_cmd_pkg.sv */
package dev_cmd_pkg;

    import usb_pkt_pkg::*;

    // Command fields, most significant first.
    typedef struct packed {
        logic [3:0]  device_idx;
        logic [3:0]  data_idx;
        logic [3:0]  freq_samp;
        logic [3:0]  filt_up;
        logic [3:0]  filt_low;
        logic [11:0] reserved;
    } dev_cmd_t;

    // One queued packet request.
    typedef struct packed {
        bag_type_t kind;
        dev_cmd_t  cmd;
    } tx_req_t;

endpackage

/* src/tx_req_fifo.sv */
`timescale 1ns/10ps

module tx_req_fifo
    import dev_cmd_pkg::*;
#(
    parameter int fifo_depth = 4
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    push,
    input  tx_req_t req,
    input  logic    pop,
    output tx_req_t head,
    output logic    empty,
    output logic    full
);

    localparam int aw = $clog2(fifo_depth);
    localparam logic [aw:0] full_level = (aw + 1)'(fifo_depth);

    tx_req_t       mem [fifo_depth];
    logic [aw-1:0] wr_ptr;
    logic [aw-1:0] rd_ptr;
    logic [aw:0]   count;
    logic          do_push;
    logic          do_pop;

    // Pushes into a full queue are dropped.
    assign do_push = push && !full;
    assign do_pop = pop && !empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= req;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head = mem[rd_ptr];
    assign empty = (count == '0);
    assign full = (count == full_level);

endmodule

/* src/tx_sequencer.sv */
`timescale 1ns/10ps

module tx_sequencer
    import usb_pkt_pkg::*, dev_cmd_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  tx_req_t   head,
    input  logic      empty,
    output logic      pop,
    output logic      fs,
    output bag_type_t btype,
    output dev_cmd_t  cache_cmd,
    input  logic      fd,
    output logic      busy
);

    typedef enum logic {
        SEQ_IDLE,
        SEQ_SEND
    } seq_state_t;

    seq_state_t state;
    logic       take;

    // Head is stale in the pop cycle, so wait for the queue to advance.
    assign take = (state == SEQ_IDLE) && !empty && !pop;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= SEQ_IDLE;
            fs <= 1'b0;
            pop <= 1'b0;
        end else begin
            pop <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (take) begin
                        fs <= 1'b1;
                        state <= SEQ_SEND;
                    end
                end
                SEQ_SEND: begin
                    if (fd) begin
                        fs <= 1'b0;
                        pop <= 1'b1;
                        state <= SEQ_IDLE;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            btype <= head.kind;
            cache_cmd <= head.cmd;
        end
    end

    // Stays high through the pop so the last byte still leaving is covered.
    assign busy = (state == SEQ_SEND) || pop;

endmodule

/* src/usb_link_tx.sv */
`timescale 1ns/10ps

module usb_link_tx
    import usb_pkt_pkg::*, dev_cmd_pkg::*;
#(
    parameter int preamble_len = 0,
    parameter int fifo_depth = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       req_push,
    input  tx_req_t    req,
    output logic       full,
    output logic       busy,
    output logic [7:0] usb_txd
);

    tx_req_t   head;
    logic      empty;
    logic      pop;
    logic      fs;
    logic      fd;
    bag_type_t btype;
    dev_cmd_t  cache_cmd;

    tx_req_fifo #(
        .fifo_depth (fifo_depth)
    ) tx_req_fifo_inst (
        .clk   (clk),
        .rst   (rst),
        .push  (req_push),
        .req   (req),
        .pop   (pop),
        .head  (head),
        .empty (empty),
        .full  (full)
    );

    tx_sequencer tx_sequencer_inst (
        .clk       (clk),
        .rst       (rst),
        .head      (head),
        .empty     (empty),
        .pop       (pop),
        .fs        (fs),
        .btype     (btype),
        .cache_cmd (cache_cmd),
        .fd        (fd),
        .busy      (busy)
    );

    usb_tx #(
        .preamble_len (preamble_len)
    ) usb_tx_inst (
        .clk       (clk),
        .rst       (rst),
        .fs        (fs),
        .fd        (fd),
        .btype     (btype),
        .cache_cmd (cache_cmd),
        .usb_txd   (usb_txd)
    );

endmodule

/* src/usb_pkt_pkg.sv */
package usb_pkt_pkg;

    // Packet kinds carried in a request.
    typedef enum logic [3:0] {
        BAG_INIT   = 4'h0,
        BAG_ACK    = 4'h1,
        BAG_NAK    = 4'h2,
        BAG_RLY    = 4'h3,
        BAG_LINK   = 4'h4,
        BAG_DIDX   = 4'h5,
        BAG_DPARAM = 4'h6,
        BAG_DDIDX  = 4'h7
    } bag_type_t;

    localparam logic [7:0] IDLE_BYTE = 8'h00;
    localparam logic [7:0] PID_SYNC  = 8'h01;
    localparam logic [7:0] PID_PREM  = 8'h5A;
    localparam logic [7:0] PID_ACK   = 8'h2D;
    localparam logic [7:0] PID_NAK   = 8'hA5;
    localparam logic [7:0] PID_RLY   = 8'hE1;
    localparam logic [7:0] PID_CMD   = 8'h1E;

    // Upper nibble of the first command byte.
    localparam logic [3:0] HEAD_DDIDX  = 4'h1;
    localparam logic [3:0] HEAD_DPARAM = 4'h5;
    localparam logic [3:0] HEAD_DIDX   = 4'h9;
    localparam logic [3:0] HEAD_LINK   = 4'hB;

    // Length field is a zero byte followed by the count.
    localparam int LEN_BYTES = 2;

    // Zero for handshakes, which carry no command bytes.
    function automatic logic [7:0] cmd_len(input bag_type_t kind);
        case (kind)
            BAG_DIDX, BAG_DDIDX, BAG_LINK: return 8'd1;
            BAG_DPARAM: return 8'd2;
            default: return 8'd0;
        endcase
    endfunction

    function automatic logic [7:0] pid_of(input bag_type_t kind);
        case (kind)
            BAG_ACK: return PID_ACK;
            BAG_NAK: return PID_NAK;
            BAG_RLY: return PID_RLY;
            BAG_INIT: return IDLE_BYTE;
            default: return PID_CMD;
        endcase
    endfunction

endpackage

/* src/usb_tx.sv */
`timescale 1ns/10ps

module usb_tx
    import usb_pkt_pkg::*, dev_cmd_pkg::*;
#(
    parameter int preamble_len = 0
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       fs,
    output logic       fd,
    input  bag_type_t  btype,
    input  dev_cmd_t   cache_cmd,
    output logic [7:0] usb_txd
);

    typedef enum logic [3:0] {
        IDLE, WAIT, PREM, SYNC, WPID, DNUM, WCMD, CRC5, WORK, DONE
    } state_t;

    localparam logic [3:0] prem_last = (preamble_len > 0) ? 4'(preamble_len - 1) : 4'd0;
    localparam logic [3:0] len_last = 4'(LEN_BYTES - 1);

    state_t     state;
    state_t     next_state;
    logic [3:0] num;
    logic [3:0] cmd_last;
    logic [7:0] dlen;
    logic [7:0] pid;
    logic [7:0] txd;
    logic [7:0] cmd_byte;
    logic       cen;
    logic [7:0] crc_out;

    assign fd = (state == DONE);
    assign cmd_last = dlen[3:0] - 4'd1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: next_state = WAIT;
            WAIT: if (fs) next_state = (preamble_len == 0) ? SYNC : PREM;
            PREM: if (num == prem_last) next_state = SYNC;
            SYNC: next_state = WPID;
            WPID: next_state = (cmd_len(btype) == 8'd0) ? DONE : DNUM;
            DNUM: if (num == len_last) next_state = WCMD;
            WCMD: if (num == cmd_last) next_state = CRC5;
            CRC5: next_state = WORK;
            WORK: next_state = DONE;
            DONE: if (!fs) next_state = WAIT;
            default: next_state = IDLE;
        endcase
    end

    // One counter paces preamble, length field and command bytes.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            num <= 4'd0;
        end else if (state == PREM && num != prem_last) begin
            num <= num + 4'd1;
        end else if (state == DNUM && num != len_last) begin
            num <= num + 4'd1;
        end else if (state == WCMD && num != cmd_last) begin
            num <= num + 4'd1;
        end else begin
            num <= 4'd0;
        end
    end

    always_ff @(posedge clk) begin
        if (state == SYNC) begin
            pid <= pid_of(btype);
        end
        if (state == WPID) begin
            dlen <= cmd_len(btype);
        end
    end

    always_comb begin
        case (btype)
            BAG_DIDX: cmd_byte = {HEAD_DIDX, cache_cmd.device_idx};
            BAG_DDIDX: cmd_byte = {HEAD_DDIDX, cache_cmd.data_idx};
            BAG_LINK: cmd_byte = {HEAD_LINK, 4'h0};
            BAG_DPARAM: begin
                if (num == 4'd0) begin
                    cmd_byte = {HEAD_DPARAM, cache_cmd.freq_samp};
                end else begin
                    cmd_byte = {cache_cmd.filt_up, cache_cmd.filt_low};
                end
            end
            default: cmd_byte = IDLE_BYTE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            txd <= IDLE_BYTE;
        end else begin
            case (state)
                PREM: txd <= PID_PREM;
                SYNC: txd <= PID_SYNC;
                WPID: txd <= pid;
                DNUM: txd <= (num == len_last) ? dlen : IDLE_BYTE;
                WCMD: txd <= cmd_byte;
                default: txd <= IDLE_BYTE;
            endcase
        end
    end

    // CRC sees the count byte and the command bytes as they sit in txd.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cen <= 1'b0;
        end else begin
            cen <= (state == DNUM && num == len_last) || (state == WCMD);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            usb_txd <= IDLE_BYTE;
        end else if (state == WORK) begin
            usb_txd <= crc_out;
        end else begin
            usb_txd <= txd;
        end
    end

    crc5 crc5_inst (
        .clk    (clk),
        .rst    (rst),
        .init   (state == WAIT),
        .enable (cen),
        .din    (txd),
        .dout   (crc_out)
    );

endmodule

/* usb_link_tx.f */
src/usb_pkt_pkg.sv
src/dev_cmd_pkg.sv
src/crc5.sv
src/usb_tx.sv
src/tx_req_fifo.sv
src/tx_sequencer.sv
src/usb_link_tx.sv
dv/tb_clock.sv
dv/usb_link_tx_properties.sv
dv/usb_link_tx_tb.sv
